//--- common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN   32  // data width
`define CSR_ADDR_W 12  // csr address space

// misa mxl field, 1 is rv32
`define CSR_MISA_MXL 2'b01

// extension letters that may be switched on
`define CSR_MISA_A 1'b0
`define CSR_MISA_C 1'b0
`define CSR_MISA_D 1'b0
`define CSR_MISA_E 1'b0
`define CSR_MISA_F 1'b0
`define CSR_MISA_I 1'b1  // base integer set
`define CSR_MISA_M 1'b1  // mul/div
`define CSR_MISA_S 1'b0  // supervisor mode
`define CSR_MISA_U 1'b0  // user mode

// letters z down to a, unlisted ones tied low
`define CSR_MISA_VALUE {`CSR_MISA_MXL, 4'b0, \
    5'b0, `CSR_MISA_U, 1'b0, `CSR_MISA_S, \
    5'b0, `CSR_MISA_M, 3'b0, `CSR_MISA_I, \
    2'b0, `CSR_MISA_F, `CSR_MISA_E, `CSR_MISA_D, \
    `CSR_MISA_C, 1'b0, `CSR_MISA_A}

`endif

//--- common/csr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    // implemented machine mode addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MCYCLE        = 12'hb00,
        CSR_MINSTRET      = 12'hb02,
        CSR_MCYCLEH       = 12'hb80,
        CSR_MINSTRETH     = 12'hb82
    } csr_addr_e;

    typedef struct packed {
        logic                   we;
        logic [`CSR_ADDR_W-1:0] addr;  // any address, not only the enum
        logic [`CSR_XLEN-1:0]   data;
    } csr_wr_t;

    // what the interrupt controller looks at
    typedef struct packed {
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mstatus;
        logic [`CSR_XLEN-1:0] mie;
    } csr_trap_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] mstatus;
        logic [`CSR_XLEN-1:0] mie;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mscratch;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] mtval;
        logic [`CSR_XLEN-1:0] mcountinhibit;
    } csr_trap_bank_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] mcycle;
        logic [`CSR_XLEN-1:0] mcycleh;
        logic [`CSR_XLEN-1:0] minstret;
        logic [`CSR_XLEN-1:0] minstreth;
    } csr_cnt_t;

    // true when the port writes the given address this cycle
    function automatic logic csr_wr_hit(input csr_wr_t wr, input csr_addr_e addr);
        return wr.we && (wr.addr == addr);
    endfunction

endpackage

`default_nettype wire

//--- csr/csr_counters.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_counters (
    input  logic              clk,
    input  logic              reset_i,
    input  csr_pkg::csr_wr_t  ex_wr_i,
    input  csr_pkg::csr_wr_t  clint_wr_i,
    input  logic              inst_valid_i,
    input  logic              inhibit_cy_i,
    input  logic              inhibit_ir_i,
    output csr_pkg::csr_cnt_t cnt_o
);

    import csr_pkg::*;

    localparam int NCNT = 2;  // 0 is mcycle, 1 is minstret

    localparam csr_addr_e LO_ADDR [NCNT] = '{CSR_MCYCLE, CSR_MINSTRET};
    localparam csr_addr_e HI_ADDR [NCNT] = '{CSR_MCYCLEH, CSR_MINSTRETH};

    logic [NCNT-1:0]      count_en;
    logic [NCNT-1:0]      ex_lo;
    logic [NCNT-1:0]      ex_hi;
    logic [NCNT-1:0]      lo_we;
    logic [NCNT-1:0]      hi_we;
    logic [NCNT-1:0]      carry;
    logic [`CSR_XLEN-1:0] lo_wdata [NCNT];
    logic [`CSR_XLEN-1:0] hi_wdata [NCNT];
    logic [`CSR_XLEN-1:0] lo_q [NCNT];
    logic [`CSR_XLEN-1:0] hi_q [NCNT];

    // cycles count freely, retired instructions only when valid
    assign count_en = {inst_valid_i && !inhibit_ir_i, !inhibit_cy_i};

    always_comb begin
        for (int i = 0; i < NCNT; i++) begin
            ex_lo[i] = csr_wr_hit(ex_wr_i, LO_ADDR[i]);
            ex_hi[i] = csr_wr_hit(ex_wr_i, HI_ADDR[i]);
            lo_we[i] = ex_lo[i] || csr_wr_hit(clint_wr_i, LO_ADDR[i]);
            hi_we[i] = ex_hi[i] || csr_wr_hit(clint_wr_i, HI_ADDR[i]);
            lo_wdata[i] = ex_lo[i] ? ex_wr_i.data : clint_wr_i.data;
            hi_wdata[i] = ex_hi[i] ? ex_wr_i.data : clint_wr_i.data;
            // only a low half that really counted can roll over
            carry[i] = count_en[i] && !lo_we[i] && (lo_q[i] == '1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NCNT; i++) begin
                lo_q[i] <= '0;
                hi_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCNT; i++) begin
                if (lo_we[i]) begin
                    lo_q[i] <= lo_wdata[i];  // write beats the increment
                end else if (count_en[i]) begin
                    lo_q[i] <= lo_q[i] + 1'b1;
                end

                if (hi_we[i]) begin
                    hi_q[i] <= hi_wdata[i] + carry[i];  // keep the carry from below
                end else if (carry[i]) begin
                    hi_q[i] <= hi_q[i] + 1'b1;
                end
            end
        end
    end

    assign cnt_o = '{
        mcycle:    lo_q[0],
        mcycleh:   hi_q[0],
        minstret:  lo_q[1],
        minstreth: hi_q[1]
    };

    // free running mcycle steps by exactly one per edge
    a_mcycle_step: assert property (
        @(posedge clk) disable iff (reset_i)
        !inhibit_cy_i && !lo_we[0] |=> cnt_o.mcycle == $past(cnt_o.mcycle) + 1'b1
    );

    // CY set in mcountinhibit freezes it
    a_mcycle_hold: assert property (
        @(posedge clk) disable iff (reset_i)
        inhibit_cy_i && !lo_we[0] |=> $stable(cnt_o.mcycle)
    );

endmodule

`default_nettype wire

//--- csr/csr_read_mux.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_read_mux (
    input  logic [`CSR_ADDR_W-1:0]  ex_raddr_i,
    input  logic [`CSR_ADDR_W-1:0]  clint_raddr_i,
    input  csr_pkg::csr_trap_bank_t bank_i,
    input  csr_pkg::csr_cnt_t       cnt_i,
    output logic [`CSR_XLEN-1:0]    ex_rdata_o,
    output logic [`CSR_XLEN-1:0]    clint_rdata_o
);

    import csr_pkg::*;

    // one decode shared by both read ports
    function automatic logic [`CSR_XLEN-1:0] csr_select(
        input logic [`CSR_ADDR_W-1:0] addr,
        input csr_trap_bank_t         bank,
        input csr_cnt_t               cnt
    );
        logic [`CSR_XLEN-1:0] rdata;

        case (addr)
            CSR_MSTATUS:       rdata = bank.mstatus;
            CSR_MISA:          rdata = `CSR_MISA_VALUE;  // fixed at build time
            CSR_MIE:           rdata = bank.mie;
            CSR_MTVEC:         rdata = bank.mtvec;
            CSR_MCOUNTINHIBIT: rdata = bank.mcountinhibit;
            CSR_MSCRATCH:      rdata = bank.mscratch;
            CSR_MEPC:          rdata = bank.mepc;
            CSR_MCAUSE:        rdata = bank.mcause;
            CSR_MTVAL:         rdata = bank.mtval;
            // counter halves
            CSR_MCYCLE:        rdata = cnt.mcycle;
            CSR_MCYCLEH:       rdata = cnt.mcycleh;
            CSR_MINSTRET:      rdata = cnt.minstret;
            CSR_MINSTRETH:     rdata = cnt.minstreth;
            default:           rdata = '0;  // unimplemented csr
        endcase
        return rdata;
    endfunction

    assign ex_rdata_o    = csr_select(ex_raddr_i, bank_i, cnt_i);
    assign clint_rdata_o = csr_select(clint_raddr_i, bank_i, cnt_i);

endmodule

`default_nettype wire

//--- csr/csr_trap_regs.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_trap_regs (
    input  logic                    clk,
    input  logic                    reset_i,
    input  csr_pkg::csr_wr_t        ex_wr_i,
    input  csr_pkg::csr_wr_t        clint_wr_i,
    output csr_pkg::csr_trap_bank_t bank_o
);

    import csr_pkg::*;

    localparam int NREG = 8;

    // index order matches the bank struct
    localparam csr_addr_e REG_ADDR [NREG] = '{
        CSR_MSTATUS,
        CSR_MIE,
        CSR_MTVEC,
        CSR_MSCRATCH,
        CSR_MEPC,
        CSR_MCAUSE,
        CSR_MTVAL,
        CSR_MCOUNTINHIBIT
    };

    logic [NREG-1:0]      ex_hit;
    logic [NREG-1:0]      clint_hit;
    logic [`CSR_XLEN-1:0] regs_q [NREG];

    // address decode per register and port
    always_comb begin
        for (int i = 0; i < NREG; i++) begin
            ex_hit[i]    = csr_wr_hit(ex_wr_i, REG_ADDR[i]);
            clint_hit[i] = csr_wr_hit(clint_wr_i, REG_ADDR[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NREG; i++) begin
                if (ex_hit[i]) begin
                    regs_q[i] <= ex_wr_i.data;  // ex wins on a shared address
                end else if (clint_hit[i]) begin
                    regs_q[i] <= clint_wr_i.data;
                end
            end
        end
    end

    assign bank_o = '{
        mstatus:       regs_q[0],
        mie:           regs_q[1],
        mtvec:         regs_q[2],
        mscratch:      regs_q[3],
        mepc:          regs_q[4],
        mcause:        regs_q[5],
        mtval:         regs_q[6],
        mcountinhibit: regs_q[7]
    };

    // data from the pipeline or the interrupt controller must be known
    // whenever it lands in one of these registers
    a_ex_data_known: assert property (
        @(posedge clk) disable iff (reset_i)
        |ex_hit |-> !$isunknown(ex_wr_i.data)
    );

    a_clint_data_known: assert property (
        @(posedge clk) disable iff (reset_i)
        |clint_hit |-> !$isunknown(clint_wr_i.data)
    );

endmodule

`default_nettype wire

//--- csr_file.f
+incdir+common
common/csr_pkg.sv
csr/csr_trap_regs.sv
csr/csr_counters.sv
csr/csr_read_mux.sv
hdl/csr_file.sv
test/csr_file_tb.sv

//--- hdl/csr_file.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_file (
    input  logic                   clk,
    input  logic                   reset_i,
    input  csr_pkg::csr_wr_t       ex_wr_i,
    input  logic [`CSR_ADDR_W-1:0] ex_raddr_i,
    input  csr_pkg::csr_wr_t       clint_wr_i,
    input  logic [`CSR_ADDR_W-1:0] clint_raddr_i,
    input  logic                   inst_valid_i,
    output logic [`CSR_XLEN-1:0]   ex_rdata_o,
    output logic [`CSR_XLEN-1:0]   clint_rdata_o,
    output csr_pkg::csr_trap_t     trap_csr_o
);

    import csr_pkg::*;

    csr_trap_bank_t trap_bank;
    csr_cnt_t       cnt;
    logic           inhibit_cy;
    logic           inhibit_ir;

    // CY is bit 0, IR is bit 2
    assign inhibit_cy = trap_bank.mcountinhibit[0];
    assign inhibit_ir = trap_bank.mcountinhibit[2];

    // trap view for the interrupt controller
    assign trap_csr_o = '{
        mtvec:   trap_bank.mtvec,
        mepc:    trap_bank.mepc,
        mstatus: trap_bank.mstatus,
        mie:     trap_bank.mie
    };

    csr_trap_regs u_trap_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_wr_i    (ex_wr_i),
        .clint_wr_i (clint_wr_i),
        .bank_o     (trap_bank)
    );

    csr_counters u_counters (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_wr_i      (ex_wr_i),
        .clint_wr_i   (clint_wr_i),
        .inst_valid_i (inst_valid_i),
        .inhibit_cy_i (inhibit_cy),
        .inhibit_ir_i (inhibit_ir),
        .cnt_o        (cnt)
    );

    csr_read_mux u_read_mux (
        .ex_raddr_i    (ex_raddr_i),
        .clint_raddr_i (clint_raddr_i),
        .bank_i        (trap_bank),
        .cnt_i         (cnt),
        .ex_rdata_o    (ex_rdata_o),
        .clint_rdata_o (clint_rdata_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the csr file testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f csr_file.f --top-module csr_file_tb -Mdir obj_dir

out=$(./obj_dir/Vcsr_file_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

//--- test/csr_file_tb.sv
`default_nettype none

module csr_file_tb;

    import csr_pkg::*;

    localparam int WAIT_LIMIT = 64;  // longest single wait in cycles

    typedef enum logic [2:0] {
        ACT_EX_WR,
        ACT_CLINT_WR,
        ACT_BOTH_WR,
        ACT_READ,
        ACT_IDLE,
        ACT_PULSE
    } act_e;

    typedef struct packed {
        logic [2:0]  tid;
        act_e        act;
        logic [11:0] addr_a;     // ex port, or the only port
        logic [11:0] addr_b;     // clint port on a dual write or split read
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic        rnd;        // data comes from the lfsr
        logic [31:0] expv;       // expected value, or offset on the model
        logic        use_model;
        logic        split;      // clint port reads addr_b instead
        logic [7:0]  count;
    } step_t;

    logic        clk = 1'b0;
    logic        reset_i;
    csr_wr_t     ex_wr;
    csr_wr_t     clint_wr;
    logic [11:0] ex_raddr;
    logic [11:0] clint_raddr;
    logic        inst_valid;
    logic [31:0] ex_rdata;
    logic [31:0] clint_rdata;
    csr_trap_t   trap_csr;

    step_t       steps [$];
    logic [31:0] shadow [logic [11:0]];  // last value written per address
    logic [31:0] lfsr_state = 32'h1d84_f1bb;
    int          build_tid;
    int          error_count;
    int          check_count;
    string       test_names [6];

    always #4 clk = ~clk;

    csr_file dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_wr_i       (ex_wr),
        .ex_raddr_i    (ex_raddr),
        .clint_wr_i    (clint_wr),
        .clint_raddr_i (clint_raddr),
        .inst_valid_i  (inst_valid),
        .ex_rdata_o    (ex_rdata),
        .clint_rdata_o (clint_rdata),
        .trap_csr_o    (trap_csr)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit shifted in
    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {lfsr_state[0], w[31:1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // addresses that hold what is written, misa and the rest drop it
    function automatic logic is_writable(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MCOUNTINHIBIT, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MCYCLE, CSR_MCYCLEH,
            CSR_MINSTRET, CSR_MINSTRETH: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return 32'h0;  // never written, still at reset value
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expv);
        check_count++;
        if (got !== expv) begin
            error_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, expv);
        end
    endtask

    task automatic wait_cycles(input int n);
        int waited;
        waited = 0;
        while (waited < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited < n) begin
            error_count++;
            $display("Timeout at %0t: only %0d of %0d cycles waited", $time, waited, n);
        end
    endtask

    task automatic write_step(input act_e act, input logic [11:0] a, input logic [11:0] b,
                              input logic rnd, input logic [31:0] d_a,
                              input logic [31:0] d_b);
        step_t s;
        s = '0;
        s.tid = build_tid[2:0];
        s.act = act;
        s.addr_a = a;
        s.addr_b = b;
        s.rnd = rnd;
        s.data_a = d_a;
        s.data_b = d_b;
        steps.push_back(s);
    endtask

    task automatic read_step(input logic [11:0] a, input logic use_model,
                             input logic [31:0] expv);
        step_t s;
        s = '0;
        s.tid = build_tid[2:0];
        s.act = ACT_READ;
        s.addr_a = a;
        s.use_model = use_model;
        s.expv = expv;
        steps.push_back(s);
    endtask

    // ex and clint read different registers in the same cycle
    task automatic split_read_step(input logic [11:0] a, input logic [11:0] b);
        step_t s;
        s = '0;
        s.tid = build_tid[2:0];
        s.act = ACT_READ;
        s.addr_a = a;
        s.addr_b = b;
        s.use_model = 1'b1;
        s.split = 1'b1;
        steps.push_back(s);
    endtask

    task automatic wait_step(input act_e act, input logic [7:0] n);
        step_t s;
        s = '0;
        s.tid = build_tid[2:0];
        s.act = act;
        s.count = n;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [11:0] trap_addrs [8];
        trap_addrs = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                       CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MCOUNTINHIBIT};
        build_tid = 0;  // reset values
        for (int i = 0; i < 8; i++) begin
            read_step(trap_addrs[i], 1'b0, 32'h0);
        end
        build_tid = 1;  // readback, ports alternate
        for (int i = 0; i < 8; i++) begin
            write_step(i % 2 ? ACT_CLINT_WR : ACT_EX_WR, trap_addrs[i], 12'h0, 1'b1, 0, 0);
            read_step(trap_addrs[i], 1'b1, 32'h0);
        end
        build_tid = 2;  // same address, then different addresses
        write_step(ACT_BOTH_WR, CSR_MSCRATCH, CSR_MSCRATCH, 1'b1, 0, 0);
        read_step(CSR_MSCRATCH, 1'b1, 32'h0);
        write_step(ACT_BOTH_WR, CSR_MEPC, CSR_MTVAL, 1'b1, 0, 0);
        read_step(CSR_MEPC, 1'b1, 32'h0);
        read_step(CSR_MTVAL, 1'b1, 32'h0);
        split_read_step(CSR_MEPC, CSR_MTVAL);
        build_tid = 3;  // mcycle inhibit, count and carry
        write_step(ACT_EX_WR, CSR_MCOUNTINHIBIT, 12'h0, 1'b0, 32'h1, 0);
        write_step(ACT_EX_WR, CSR_MCYCLE, 12'h0, 1'b1, 0, 0);
        wait_step(ACT_IDLE, 8'd3);
        read_step(CSR_MCYCLE, 1'b1, 32'h0);
        write_step(ACT_EX_WR, CSR_MCOUNTINHIBIT, 12'h0, 1'b0, 32'h0, 0);
        wait_step(ACT_IDLE, 8'd5);
        read_step(CSR_MCYCLE, 1'b1, 32'd5);
        write_step(ACT_BOTH_WR, CSR_MCYCLE, CSR_MCYCLEH, 1'b0, 32'hffff_ffff, 32'h0);
        read_step(CSR_MCYCLEH, 1'b0, 32'h0);
        read_step(CSR_MCYCLEH, 1'b0, 32'h1);  // rolled over on the second edge
        read_step(CSR_MCYCLE, 1'b0, 32'h1);
        build_tid = 4;  // minstret
        write_step(ACT_EX_WR, CSR_MCOUNTINHIBIT, 12'h0, 1'b0, 32'h1, 0);
        write_step(ACT_CLINT_WR, CSR_MINSTRET, 12'h0, 1'b1, 0, 0);
        read_step(CSR_MINSTRET, 1'b1, 32'h0);
        wait_step(ACT_PULSE, 8'd6);
        read_step(CSR_MINSTRET, 1'b1, 32'd6);
        write_step(ACT_EX_WR, CSR_MCOUNTINHIBIT, 12'h0, 1'b0, 32'h5, 0);
        wait_step(ACT_PULSE, 8'd4);
        read_step(CSR_MINSTRET, 1'b1, 32'd6);
        build_tid = 5;  // misa and unimplemented space
        read_step(CSR_MISA, 1'b0, 32'h4000_1100);  // mxl 1, I and M
        write_step(ACT_EX_WR, CSR_MISA, 12'h0, 1'b1, 0, 0);
        read_step(CSR_MISA, 1'b0, 32'h4000_1100);
        write_step(ACT_BOTH_WR, 12'h7c0, 12'h306, 1'b1, 0, 0);
        read_step(12'h7c0, 1'b0, 32'h0);
        read_step(12'h306, 1'b0, 32'h0);
        read_step(CSR_MSCRATCH, 1'b1, 32'h0);
        read_step(CSR_MCAUSE, 1'b1, 32'h0);
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] d_a;
        logic [31:0] d_b;
        logic [31:0] expv;
        logic [31:0] expv_b;
        d_a = s.data_a;
        d_b = s.data_b;
        case (s.act)
            ACT_EX_WR, ACT_CLINT_WR, ACT_BOTH_WR: begin
                if (s.rnd) begin
                    draw_word(d_a);
                    if (s.act == ACT_BOTH_WR) begin
                        draw_word(d_b);
                    end
                end
                if (s.act == ACT_CLINT_WR) begin
                    clint_wr = '{we: 1'b1, addr: s.addr_a, data: d_a};
                end else begin
                    ex_wr = '{we: 1'b1, addr: s.addr_a, data: d_a};
                    if (s.act == ACT_BOTH_WR) begin
                        clint_wr = '{we: 1'b1, addr: s.addr_b, data: d_b};
                    end
                end
                wait_cycles(1);
                // clint first so ex overwrites it on a shared address
                if (clint_wr.we && is_writable(clint_wr.addr)) begin
                    shadow[clint_wr.addr] = clint_wr.data;
                end
                if (ex_wr.we && is_writable(ex_wr.addr)) begin
                    shadow[ex_wr.addr] = ex_wr.data;
                end
                ex_wr.we = 1'b0;
                clint_wr.we = 1'b0;
            end
            ACT_READ: begin
                ex_raddr = s.addr_a;
                clint_raddr = s.split ? s.addr_b : s.addr_a;
                #1;
                expv = s.use_model ? model_read(s.addr_a) + s.expv : s.expv;
                expv_b = s.use_model ? model_read(clint_raddr) + s.expv : s.expv;
                check_value($sformatf("ex read %h", s.addr_a), ex_rdata, expv);
                check_value($sformatf("clint read %h", clint_raddr), clint_rdata, expv_b);
                check_value("trap mtvec", trap_csr.mtvec, model_read(CSR_MTVEC));
                check_value("trap mepc", trap_csr.mepc, model_read(CSR_MEPC));
                check_value("trap mstatus", trap_csr.mstatus, model_read(CSR_MSTATUS));
                check_value("trap mie", trap_csr.mie, model_read(CSR_MIE));
                wait_cycles(1);
            end
            ACT_IDLE: wait_cycles(s.count);
            ACT_PULSE: begin
                for (int k = 0; k < s.count; k++) begin
                    inst_valid = 1'b1;
                    wait_cycles(1);
                    inst_valid = 1'b0;
                    wait_cycles(1);
                end
            end
            default: wait_cycles(1);
        endcase
    endtask

    initial begin
        int cur_tid;
        int test_start;
        int tests_run;
        int tests_failed;
        reset_i = 1'b1;
        ex_wr = '0;
        clint_wr = '0;
        ex_raddr = '0;
        clint_raddr = '0;
        inst_valid = 1'b0;
        error_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        test_names = '{"reset values", "trap register readback", "port collisions",
                       "mcycle", "minstret", "misa and unimplemented"};
        build_table();
        wait_cycles(8);
        reset_i = 1'b0;
        cur_tid = steps[0].tid;
        test_start = error_count;
        for (int i = 0; i <= steps.size(); i++) begin
            if (i == steps.size() || steps[i].tid != cur_tid) begin
                tests_run++;
                if (error_count != test_start) begin
                    tests_failed++;
                end
                $display("test %0d %s: %s, %0d errors", cur_tid, test_names[cur_tid],
                         error_count == test_start ? "ok" : "failed",
                         error_count - test_start);
                if (i == steps.size()) begin
                    break;
                end
                cur_tid = steps[i].tid;
                test_start = error_count;
            end
            apply_step(steps[i]);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
